// File: sources.f
+incdir+.
hdl/sata_fis_pkg.sv
hdl/sata_link_pkg.sv
hdl/word_fifo.sv
hdl/h2d_frame_scheduler.sv
hdl/d2h_fis_tagger.sv
hdl/sata_transport_fifos.sv
test/sata_transport_properties.sv
test/tb_sata_transport_fifos.sv

// File: run_sim.sh
#!/bin/sh
# build and run the SATA transport FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_sata_transport_fifos
OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    --top-module "$TOP" \
    --Mdir "$OBJ" \
    -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running after an assertion error so the testbench can report it
"./$OBJ/V$TOP" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi

// File: test/tb_sata_transport_fifos.sv
/*
 * Testbench for the SATA transport FIFOs
 * host writer, link transmit and receive models and a host reader
 * data checked against queues and protocol by the bound properties
 */
`timescale 1ns/1ps
`include "sata_xport_macros.svh"

module tb_sata_transport_fifos;
    localparam int TIMEOUT = 2000;                   // cycles per wait

    logic                    clk;
    logic                    rst;
    logic [31:0]             h2d_data;
    logic [1:0]              h2d_mask;
    sata_fis_pkg::h2d_type_e h2d_type;
    logic                    h2d_valid;
    logic                    h2d_ready;
    logic [31:0]             d2h_data;
    logic [1:0]              d2h_mask;
    sata_fis_pkg::d2h_type_e d2h_type;
    logic                    d2h_valid;
    logic                    d2h_many;
    logic                    d2h_ready;
    logic                    d2h_overflow;
    logic [31:0]             ll_tx_data;
    logic [1:0]              ll_tx_mask;
    logic                    ll_tx_last;
    logic                    ll_tx_valid;
    logic                    ll_tx_strobe;
    logic [31:0]             ll_rx_data;
    logic [1:0]              ll_rx_mask;
    logic                    ll_rx_valid;
    logic                    ll_rx_busy;
    logic                    frame_req;
    logic                    frame_busy;
    logic                    incom_start;
    logic                    incom_done;
    logic                    incom_invalidate;

    logic [34:0] tx_exp[$];                          // {last, mask, data}
    logic [35:0] rx_exp[$];                          // {type, mask, data}
    integer      seed;
    logic        tx_pop_en = 1'b0;                   // link drains host FIFO
    logic        rx_pop_en = 1'b0;                   // host drains device FIFO
    int          errors = 0;
    int          mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          req_count = 0;
    int          req_words = 0;                      // host words driven at last frame_req
    int          h2d_words = 0;
    int          rx_read = 0;

    sata_transport_fifos dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic check_word(input string what, input logic [35:0] got, input logic [35:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic start_test();
        mark = errors + dut.props.fail_count;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors + dut.props.fail_count == mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED", tests_run, name);
        end
    endtask

    // writes head, n_body data words and a last word while ready
    task automatic write_fis(input int n_body);
        int          n;
        int          waited;
        logic [31:0] data;
        logic [1:0]  mask;
        for (n = 0; n < n_body + 2; n++) begin
            waited = 0;
            while (!h2d_ready && waited < TIMEOUT) begin
                h2d_valid = 1'b0;
                tick();
                waited++;
            end
            if (!h2d_ready) begin
                report_timeout("h2d_ready");
            end
            data = $random(seed);
            mask = 2'($random(seed));
            h2d_data = data;
            h2d_mask = mask;
            h2d_type = (n == 0) ? sata_fis_pkg::FIS_HEAD :
                       (n == n_body + 1) ? sata_fis_pkg::FIS_LAST : sata_fis_pkg::FIS_DATA;
            h2d_valid = 1'b1;
            tx_exp.push_back({(n == n_body + 1), mask, data});
            h2d_words++;
            tick();
        end
        h2d_valid = 1'b0;
    endtask

    // incoming frame of n_words with optional fill level checks
    task automatic rx_frame(input int n_words, input bit bad, input bit levels);
        int          n;
        logic [31:0] data;
        logic [1:0]  mask;
        incom_start = 1'b1;
        tick();
        incom_start = 1'b0;
        for (n = 0; n < n_words; n++) begin
            if (levels) begin                        // n words already in the FIFO
                check_bit("d2h_many", d2h_many, n >= `SATA_D2H_MANY);
                check_bit("ll_rx_busy", ll_rx_busy, n >= `SATA_D2H_ALMOST_FULL);
            end
            data = $random(seed);
            mask = 2'($random(seed));
            ll_rx_data = data;
            ll_rx_mask = mask;
            ll_rx_valid = 1'b1;
            rx_exp.push_back({(n == 0) ? sata_fis_pkg::D2H_FIS_HEAD : sata_fis_pkg::DMA,
                              mask, data});
            tick();
        end
        ll_rx_valid = 1'b0;
        incom_done = !bad;
        incom_invalidate = bad;
        rx_exp.push_back({bad ? sata_fis_pkg::R_ERR : sata_fis_pkg::R_OK, 34'h0});
        tick();
        incom_done = 1'b0;
        incom_invalidate = 1'b0;
        tick();                                      // status word lands here
    endtask

    task automatic wait_req(input int target);
        int waited = 0;
        while (req_count < target && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (req_count < target) begin
            report_timeout("frame_req");
        end
    endtask

    task automatic wait_tx_drain();
        int waited = 0;
        while ((tx_exp.size() != 0 || ll_tx_valid) && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (tx_exp.size() != 0 || ll_tx_valid) begin
            report_timeout("host FIFO to drain to the link");
        end
    endtask

    task automatic wait_rx_drain();
        int waited = 0;
        while ((rx_exp.size() != 0 || d2h_valid) && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (rx_exp.size() != 0 || d2h_valid) begin
            report_timeout("device FIFO to drain to the host");
        end
    endtask

    // link transmit model pops whatever is offered when enabled
    initial begin
        ll_tx_strobe = 1'b0;
        forever begin
            tick();
            ll_tx_strobe = 1'b0;
            if (tx_pop_en && ll_tx_valid) begin
                if (tx_exp.size() == 0) begin
                    errors++;
                    $display("unexpected word on link transmit at %0t ns", $time);
                end else begin
                    check_word("link tx word", {1'b0, ll_tx_last, ll_tx_mask, ll_tx_data},
                               {1'b0, tx_exp.pop_front()});
                end
                ll_tx_strobe = 1'b1;                 // pop on next edge
            end
        end
    end

    // host reader compares status words on type only
    initial begin : host_reader
        logic [35:0] exp;
        d2h_ready = 1'b0;
        forever begin
            tick();
            d2h_ready = 1'b0;
            if (rx_pop_en && d2h_valid) begin
                if (rx_exp.size() == 0) begin
                    errors++;
                    $display("unexpected word on device to host side at %0t ns", $time);
                end else begin
                    exp = rx_exp.pop_front();
                    if (exp[35:34] == sata_fis_pkg::R_OK ||
                        exp[35:34] == sata_fis_pkg::R_ERR) begin
                        check_word("d2h status", {d2h_type, 34'h0}, exp);
                    end else begin
                        check_word("d2h word", {d2h_type, d2h_mask, d2h_data}, exp);
                    end
                end
                rx_read++;
                d2h_ready = 1'b1;
            end
        end
    end

    // frame_req counted mid-cycle since it is one cycle wide
    initial begin
        forever begin
            @(negedge clk);
            if (frame_req) begin
                req_count++;
                req_words = h2d_words;
            end
        end
    end

    initial begin
        int base;
        seed = 7;
        rst = 1'b1;
        h2d_data = '0;
        h2d_mask = '0;
        h2d_type = sata_fis_pkg::FIS_DATA;
        h2d_valid = 1'b0;
        ll_rx_data = '0;
        ll_rx_mask = '0;
        ll_rx_valid = 1'b0;
        frame_busy = 1'b0;
        incom_start = 1'b0;
        incom_done = 1'b0;
        incom_invalidate = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test();
        check_bit("frame_req", frame_req, 1'b0);
        check_bit("d2h_valid", d2h_valid, 1'b0);
        check_bit("ll_tx_valid", ll_tx_valid, 1'b0);
        check_bit("d2h_overflow", d2h_overflow, 1'b0);
        check_bit("h2d_ready", h2d_ready, 1'b1);
        end_test("reset state");

        start_test();
        base = req_count;
        write_fis(3);
        wait_req(base + 1);
        tx_pop_en = 1'b1;                            // link answers the request
        wait_tx_drain();
        repeat (4) tick();
        check_count("frame requests", req_count - base, 1);
        end_test("short FIS to link");

        start_test();
        tx_pop_en = 1'b0;
        base = req_count;
        write_fis(98);                               // 100 words
        wait_req(base + 1);
        check_bit("frame_req before last word", req_words < 100, 1'b1);
        check_bit("frame_req after threshold", req_words >= (1 << `SATA_XMIT_START_LOG2), 1'b1);
        tx_pop_en = 1'b1;
        wait_tx_drain();
        tx_pop_en = 1'b0;
        frame_busy = 1'b1;
        base = req_count;
        write_fis(98);
        repeat (20) tick();
        check_count("frame requests while busy", req_count - base, 0);
        frame_busy = 1'b0;
        wait_req(base + 1);
        tx_pop_en = 1'b1;
        wait_tx_drain();
        end_test("long FIS threshold and busy");

        start_test();
        base = rx_read;
        rx_pop_en = 1'b1;
        rx_frame(5, 1'b0, 1'b0);
        rx_frame(5, 1'b1, 1'b0);
        wait_rx_drain();
        check_count("words read by host", rx_read - base, 12);
        end_test("received frames with status");

        start_test();
        base = rx_read;
        rx_pop_en = 1'b0;
        rx_frame(70, 1'b0, 1'b1);
        check_bit("d2h_valid held", d2h_valid, 1'b1);
        check_bit("d2h_many held", d2h_many, 1'b1);
        check_bit("ll_rx_busy held", ll_rx_busy, 1'b1);
        rx_pop_en = 1'b1;
        wait_rx_drain();
        check_count("words read by host", rx_read - base, 71);
        check_bit("ll_rx_busy after drain", ll_rx_busy, 1'b0);
        end_test("device FIFO back-pressure");

        $display("%0d tests run, %0d failed, %0d value errors, %0d assertion failures",
                 tests_run, tests_failed, errors, dut.props.fail_count);
        if (tests_failed == 0 && errors == 0 && dut.props.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: test/sata_transport_properties.sv
/*
 * SATA transport protocol checker
 * bound into the transport block to watch reset state, frame requests,
 * receive flow control and the status word closing each received FIS
 */
`timescale 1ns/1ps
`include "sata_xport_macros.svh"

module sata_transport_properties (
    input logic                     clk,
    input logic                     rst,
    input logic                     h2d_valid,       // host FIFO write
    input sata_fis_pkg::h2d_type_e  h2d_type,
    input logic                     frame_req,
    input logic                     frame_busy,
    input sata_link_pkg::tx_state_e sched_state,     // scheduler FSM state
    input logic                     d2h_valid,
    input logic                     d2h_ready,
    input logic                     ll_tx_valid,
    input logic                     d2h_overflow,
    input logic                     h2d_ready,
    input logic                     ll_rx_busy,
    input logic                     d2h_wr,          // device FIFO write
    input sata_fis_pkg::d2h_type_e  rx_type,         // tag of the word being written
    input logic                     incom_done,
    input logic                     incom_invalidate
);
    localparam logic [`SATA_FIFO_AW:0] FULL_FILL =
        (`SATA_FIFO_AW + 1)'(1 << `SATA_FIFO_AW);
    localparam logic [`SATA_FIFO_AW:0] BUSY_FILL =
        (`SATA_FIFO_AW + 1)'(`SATA_D2H_ALMOST_FULL);

    int                     fail_count = 0;          // assertion failures so far
    logic                   head_pending;            // head written, no request since
    logic [`SATA_FIFO_AW:0] rx_words;                // device FIFO words seen at the ports
    logic                   rx_push;
    logic                   rx_pop;

    assign rx_pop  = d2h_valid && d2h_ready;
    assign rx_push = d2h_wr && (rx_words != FULL_FILL || rx_pop);  // full FIFO drops it

    // heads waiting for their frame request
    always_ff @(posedge clk) begin
        if (rst) begin
            head_pending <= 1'b0;
        end else if (h2d_valid && h2d_type == sata_fis_pkg::FIS_HEAD) begin
            head_pending <= 1'b1;                    // also a head in the request cycle
        end else if (frame_req) begin
            head_pending <= 1'b0;
        end
    end

    // receive occupancy from writes and host pops
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_words <= '0;
        end else begin
            case ({rx_push, rx_pop})
                2'b10:   rx_words <= rx_words + 1'b1;
                2'b01:   rx_words <= rx_words - 1'b1;
                default: rx_words <= rx_words;
            endcase
        end
    end

    // everything idle on the cycle after a reset edge
    reset_state: assert property (@(posedge clk)
        rst |=> !frame_req && !d2h_valid && !ll_tx_valid && !d2h_overflow && h2d_ready)
        else begin
            fail_count++;
            $error("outputs not idle after reset");
        end

    // each request consumes one pending head
    req_once: assert property (@(posedge clk) disable iff (rst)
        frame_req |-> head_pending)
        else begin
            fail_count++;
            $error("frame_req without a pending FIS head");
        end

    // scheduler back in IDLE once its head was served
    req_idle: assert property (@(posedge clk) disable iff (rst)
        !head_pending |-> sched_state == sata_link_pkg::IDLE)
        else begin
            fail_count++;
            $error("scheduler not idle with no FIS head pending");
        end

    req_not_busy: assert property (@(posedge clk) disable iff (rst)
        frame_req |-> $past(!frame_busy))
        else begin
            fail_count++;
            $error("frame_req while link was busy");
        end

    // flow control against the word count kept here
    rx_busy_level: assert property (@(posedge clk) disable iff (rst)
        ll_rx_busy == (rx_words >= BUSY_FILL))
        else begin
            fail_count++;
            $error("ll_rx_busy does not match device FIFO fill");
        end

    status_ok: assert property (@(posedge clk) disable iff (rst)
        incom_done && !incom_invalidate && rx_type == sata_fis_pkg::DMA
        |=> d2h_wr && rx_type == sata_fis_pkg::R_OK)
        else begin
            fail_count++;
            $error("no R_OK word after a good frame");
        end

    status_err: assert property (@(posedge clk) disable iff (rst)
        incom_invalidate && rx_type == sata_fis_pkg::DMA
        |=> d2h_wr && rx_type == sata_fis_pkg::R_ERR)
        else begin
            fail_count++;
            $error("no R_ERR word after an invalidated frame");
        end

endmodule

bind sata_transport_fifos sata_transport_properties props (
    .clk              (clk),
    .rst              (rst),
    .h2d_valid        (h2d_valid),
    .h2d_type         (h2d_type),
    .frame_req        (frame_req),
    .frame_busy       (frame_busy),
    .sched_state      (h2d_sched.state),
    .d2h_valid        (d2h_valid),
    .d2h_ready        (d2h_ready),
    .ll_tx_valid      (ll_tx_valid),
    .d2h_overflow     (d2h_overflow),
    .h2d_ready        (h2d_ready),
    .ll_rx_busy       (ll_rx_busy),
    .d2h_wr           (d2h_wr),
    .rx_type          (rx_type),
    .incom_done       (incom_done),
    .incom_invalidate (incom_invalidate)
);

// File: hdl/sata_transport_fifos.sv
/*
 * SATA transport buffering
 * host and device word FIFOs between host controller and link layer,
 * frame request scheduling and receive FIS tagging
 */
`timescale 1ns/1ps
`include "sata_xport_macros.svh"

module sata_transport_fifos (
    input  logic                    clk,
    input  logic                    rst,
    // host to device
    input  logic [31:0]             h2d_data,
    input  logic [1:0]              h2d_mask,          // passed through untouched
    input  sata_fis_pkg::h2d_type_e h2d_type,
    input  logic                    h2d_valid,         // one word per cycle
    output logic                    h2d_ready,         // room for at least 8 more
    // device to host
    output logic [31:0]             d2h_data,
    output logic [1:0]              d2h_mask,
    output sata_fis_pkg::d2h_type_e d2h_type,
    output logic                    d2h_valid,
    output logic                    d2h_many,          // several words queued
    input  logic                    d2h_ready,
    output logic                    d2h_overflow,      // receive word lost
    // link transmit
    output logic [31:0]             ll_tx_data,
    output logic [1:0]              ll_tx_mask,
    output logic                    ll_tx_last,
    output logic                    ll_tx_valid,
    input  logic                    ll_tx_strobe,      // link pops head word
    // link receive
    input  logic [31:0]             ll_rx_data,
    input  logic [1:0]              ll_rx_mask,
    input  logic                    ll_rx_valid,
    output logic                    ll_rx_busy,        // device FIFO almost full
    // link control
    output logic                    frame_req,
    input  logic                    frame_busy,
    input  logic                    incom_start,
    input  logic                    incom_done,
    input  logic                    incom_invalidate
);
    localparam int AW = `SATA_FIFO_AW;
    localparam logic [AW:0] H2D_READY_MAX = (AW + 1)'((1 << AW) - `SATA_H2D_ROOM);
    localparam logic [AW:0] D2H_MANY_FILL = (AW + 1)'(`SATA_D2H_MANY);
    localparam logic [AW:0] D2H_BUSY_FILL = (AW + 1)'(`SATA_D2H_ALMOST_FULL);

    logic [`SATA_FIFO_WORD_W-1:0] h2d_rd_word;
    logic [AW:0]                  h2d_fill;
    logic [`SATA_FIFO_WORD_W-1:0] d2h_rd_word;
    logic [AW:0]                  d2h_fill;
    logic                         d2h_wr;
    sata_fis_pkg::d2h_type_e      rx_type;
    logic                         d2h_rd;

    // host side, word layout {type, mask, data}
    word_fifo #(.AW(AW)) h2d_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (h2d_valid),
        .wr_word   ({h2d_type, h2d_mask, h2d_data}),
        .rd_en     (ll_tx_strobe),                 // strobe on empty is ignored inside
        .rd_word   (h2d_rd_word),
        .not_empty (ll_tx_valid),
        .fill      (h2d_fill),
        .overflow  ()                              // host respects h2d_ready
    );

    assign ll_tx_data = h2d_rd_word[31:0];
    assign ll_tx_mask = h2d_rd_word[33:32];
    assign ll_tx_last = (h2d_rd_word[35:34] == sata_fis_pkg::FIS_LAST);
    assign h2d_ready  = h2d_fill <= H2D_READY_MAX;

    h2d_frame_scheduler h2d_sched (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (h2d_valid),
        .wr_type    (h2d_type),
        .fifo_fill  (h2d_fill),
        .frame_busy (frame_busy),
        .frame_req  (frame_req)
    );

    // receive side
    d2h_fis_tagger d2h_tagger (
        .clk              (clk),
        .rst              (rst),
        .rx_valid         (ll_rx_valid),
        .incom_start      (incom_start),
        .incom_done       (incom_done),
        .incom_invalidate (incom_invalidate),
        .fifo_wr          (d2h_wr),
        .word_type        (rx_type)
    );

    assign d2h_rd = d2h_valid && d2h_ready;

    word_fifo #(.AW(AW)) d2h_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (d2h_wr),
        .wr_word   ({rx_type, ll_rx_mask, ll_rx_data}),  // data unused on status words
        .rd_en     (d2h_rd),
        .rd_word   (d2h_rd_word),
        .not_empty (d2h_valid),
        .fill      (d2h_fill),
        .overflow  (d2h_overflow)
    );

    assign d2h_data   = d2h_rd_word[31:0];
    assign d2h_mask   = d2h_rd_word[33:32];
    assign d2h_type   = sata_fis_pkg::d2h_type_e'(d2h_rd_word[35:34]);
    assign d2h_many   = d2h_fill >= D2H_MANY_FILL;
    assign ll_rx_busy = d2h_fill >= D2H_BUSY_FILL;   // link holds off from here

endmodule

// File: hdl/d2h_fis_tagger.sv
/*
 * Device-to-host FIS tagger
 * marks link receive words as head or body and appends one
 * R_OK/R_ERR status word after a frame that carried data
 */
`timescale 1ns/1ps

module d2h_fis_tagger (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rx_valid,          // link word this cycle
    input  logic                    incom_start,       // new incoming frame
    input  logic                    incom_done,        // frame ended, CRC good
    input  logic                    incom_invalidate,  // frame ended with errors
    output logic                    fifo_wr,           // device FIFO write
    output sata_fis_pkg::d2h_type_e word_type          // tag for the written word
);
    sata_fis_pkg::d2h_type_e type_r;
    logic                    over_r;                    // status word due
    logic                    fis_end;

    assign fis_end = incom_done || incom_invalidate;

    // current tag, head first then body, status once data was seen
    always_ff @(posedge clk) begin
        if (rst || incom_start) begin
            type_r <= sata_fis_pkg::D2H_FIS_HEAD;
        end else if (fis_end && (type_r == sata_fis_pkg::DMA)) begin
            type_r <= incom_invalidate ? sata_fis_pkg::R_ERR : sata_fis_pkg::R_OK;
        end else if (rx_valid) begin
            type_r <= sata_fis_pkg::DMA;                // body from here on
        end
    end

    // leaving DMA means only one status word per FIS
    always_ff @(posedge clk) begin
        if (rst) begin
            over_r <= 1'b0;
        end else begin
            over_r <= fis_end && (type_r == sata_fis_pkg::DMA);
        end
    end

    assign fifo_wr   = rx_valid || over_r;              // status word rides on over_r
    assign word_type = type_r;

endmodule

// File: hdl/h2d_frame_scheduler.sv
/*
 * Host-to-device frame scheduler
 * watches FIS heads entering the host FIFO and asks the link for a frame
 * once the FIS is complete or enough words are buffered
 */
`timescale 1ns/1ps
`include "sata_xport_macros.svh"

module h2d_frame_scheduler (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_en,       // host FIFO write
    input  sata_fis_pkg::h2d_type_e wr_type,     // type of the word being written
    input  logic [`SATA_FIFO_AW:0]  fifo_fill,   // host FIFO occupancy
    input  logic                    frame_busy,  // link cannot take a request
    output logic                    frame_req    // one-cycle request to link
);
    localparam logic [`SATA_FIFO_AW:0] START_FILL =
        (`SATA_FIFO_AW + 1)'(1 << `SATA_XMIT_START_LOG2);

    sata_link_pkg::tx_state_e state;
    sata_link_pkg::tx_state_e state_nxt;
    logic                     head_wr;
    logic                     last_wr;
    logic                     enough;
    logic                     start;

    assign head_wr = wr_en && (wr_type == sata_fis_pkg::FIS_HEAD);
    assign last_wr = wr_en && (wr_type == sata_fis_pkg::FIS_LAST);
    assign enough  = fifo_fill >= START_FILL;          // long FIS, don't wait for last
    assign start   = !frame_busy && (last_wr || enough);

    always_comb begin
        state_nxt = state;
        case (state)
            sata_link_pkg::IDLE: begin
                if (head_wr) begin
                    state_nxt = sata_link_pkg::FILLING;
                end
            end
            sata_link_pkg::FILLING: begin
                if (start) begin
                    state_nxt = sata_link_pkg::REQUESTED;   // req shows next cycle
                end
            end
            sata_link_pkg::REQUESTED: begin
                // back-to-back FIS, head may land in the request cycle
                state_nxt = head_wr ? sata_link_pkg::FILLING : sata_link_pkg::IDLE;
            end
            default: state_nxt = sata_link_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sata_link_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign frame_req = (state == sata_link_pkg::REQUESTED);  // decoded from a flop

endmodule

// File: hdl/word_fifo.sv
/*
 * Single-clock show-ahead word FIFO
 * head word is visible on rd_word whenever not_empty is high,
 * fill count tracks occupancy, writes while full are dropped and flagged
 */
`timescale 1ns/1ps
`include "sata_xport_macros.svh"

module word_fifo #(
    parameter int AW = 4                             // address bits, depth is 2**AW
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wr_en,      // push wr_word
    input  logic [`SATA_FIFO_WORD_W-1:0] wr_word,
    input  logic                         rd_en,      // pop, ignored when empty
    output logic [`SATA_FIFO_WORD_W-1:0] rd_word,    // current head word
    output logic                         not_empty,
    output logic [AW:0]                  fill,       // words held, 0..2**AW
    output logic                         overflow    // one cycle after a dropped write
);
    localparam int DEPTH = 1 << AW;

    logic [`SATA_FIFO_WORD_W-1:0] mem [DEPTH];
    logic [AW-1:0]                wr_ptr;
    logic [AW-1:0]                rd_ptr;
    logic                         full;
    logic                         wr_ok;
    logic                         rd_ok;

    assign full      = fill[AW];                     // top bit only set at DEPTH
    assign not_empty = |fill;
    assign rd_ok     = rd_en && not_empty;
    assign wr_ok     = wr_en && (!full || rd_ok);    // a pop frees room same cycle

    // asynchronous read gives the show-ahead head word
    assign rd_word = mem[rd_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    // pointers
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;             // wraps at DEPTH
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            fill <= '0;
        end else begin
            case ({wr_ok, rd_ok})
                2'b10:   fill <= fill + 1'b1;        // push only
                2'b01:   fill <= fill - 1'b1;        // pop only
                default: fill <= fill;               // both or neither
            endcase
        end
    end

    // dropped write indicator
    always_ff @(posedge clk) begin
        if (rst) begin
            overflow <= 1'b0;
        end else begin
            overflow <= wr_en && !wr_ok;             // pulse per lost word
        end
    end

endmodule

// File: hdl/sata_link_pkg.sv
/*
 * SATA link handshake types
 * transmit request tracking between host FIFO and link layer
 */
package sata_link_pkg;

    // frame request state
    // one request per FIS head; the request cycle itself is REQUESTED
    typedef enum logic [1:0] {
        IDLE      = 2'd0,  // no FIS pending
        FILLING   = 2'd1,  // head seen, waiting for last word or threshold
        REQUESTED = 2'd2   // frame_req high for this cycle
    } tx_state_e;

endpackage

// File: hdl/sata_fis_pkg.sv
/*
 * SATA FIS word types
 * tags carried in the top two bits of every FIFO word, per direction
 */
package sata_fis_pkg;

    // host to device, written by the host with each word
    typedef enum logic [1:0] {
        FIS_DATA = 2'd0,  // body word
        FIS_HEAD = 2'd1,  // first word of a FIS
        FIS_LAST = 2'd2   // final word, starts transmit if not yet started
    } h2d_type_e;

    // device to host, produced by the receive tagger
    // status words come after the body, their data field carries nothing
    typedef enum logic [1:0] {
        DMA          = 2'd0,  // FIS body
        D2H_FIS_HEAD = 2'd1,  // first word after incom_start
        R_OK         = 2'd2,  // frame closed cleanly
        R_ERR        = 2'd3   // frame invalidated by the link
    } d2h_type_e;

endpackage

// File: sata_xport_macros.svh
/*
 * SATA transport FIFO constants
 * depth, word layout width and the fill thresholds used on both sides
 */
`ifndef SATA_XPORT_MACROS_SVH
`define SATA_XPORT_MACROS_SVH

// fifo geometry
`define SATA_FIFO_AW          9   // address bits, 512 words per direction
`define SATA_FIFO_WORD_W      36  // {type[1:0], mask[1:0], data[31:0]}

// host to device
`define SATA_XMIT_START_LOG2  6   // ask link for a frame once 64 words are buffered
`define SATA_H2D_ROOM         8   // ready only while this many words are still free

// device to host
`define SATA_D2H_MANY         8   // d2h_many threshold
`define SATA_D2H_ALMOST_FULL  63  // tell link to hold off at this fill

`endif
